// File: Makefile
TOP = denseLayerTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --assert --top-module $(TOP) -Mdir obj_dir -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// File: design/actArbiter.sv
`timescale 1ns/1ps

module actArbiter #(
	parameter int NUM_NEURONS = 2
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [NUM_NEURONS-1:0]     readReq,
	input  logic [NUM_NEURONS*5-1:0]   reqAddr,
	output logic [NUM_NEURONS-1:0]     grant,
	output logic [4:0]                 readAddr
);

	localparam int PTR_W = (NUM_NEURONS > 1) ? $clog2(NUM_NEURONS) : 1;

	logic [PTR_W-1:0] ptr;   // first engine to be considered this cycle
	int winner;
	logic found;

	always_comb
	begin
		int idx;
		grant = '0;
		winner = int'(ptr);
		found = 1'b0;
		for (int i = 0; i < NUM_NEURONS; i++)
		begin
			idx = (int'(ptr) + i) % NUM_NEURONS;
			if (!found && readReq[idx])
			begin
				found = 1'b1;
				winner = idx;
			end
		end
		if (found)
			grant[winner] = 1'b1;
	end

	assign readAddr = reqAddr[winner*5 +: 5];

	always_ff @(posedge clk)
	begin
		if (reset)
			ptr <= '0;
		else if (found)
			ptr <= PTR_W'((winner + 1) % NUM_NEURONS);   // the winner goes to the back
	end

	grantOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant));

	grantToRequester: assert property (@(posedge clk) disable iff (reset)
		(grant & ~readReq) == '0);

endmodule

// File: design/actBuffer.sv
`timescale 1ns/1ps

module actBuffer #(
	parameter int NUM_INPUTS = 30
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            actWrite,
	input  logic [4:0]                      actAddr,
	input  logic signed [nnPkg::ACT_W-1:0]  actData,
	input  logic [4:0]                      readAddr,
	output logic signed [nnPkg::ACT_W-1:0]  readData
);

	logic signed [nnPkg::ACT_W-1:0] mem [NUM_INPUTS];

	always_ff @(posedge clk)
	begin
		if (actWrite && (actAddr < NUM_INPUTS))
		begin
			mem[actAddr] <= actData;
		end
	end

	// a read in the same cycle as a write to that word returns the old value
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			readData <= '0;
		end
		else
		begin
			readData <= (readAddr < NUM_INPUTS) ? mem[readAddr] : '0;
		end
	end

endmodule

// File: design/denseLayer.sv
`timescale 1ns/1ps

module denseLayer #(
	parameter int NUM_INPUTS = 30,
	parameter int NUM_NEURONS = 2
) (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     actWrite,
	input  logic [4:0]                               actAddr,
	input  logic signed [nnPkg::ACT_W-1:0]           actData,
	input  logic                                     start,
	output logic [NUM_NEURONS-1:0]                   done,
	output logic [NUM_NEURONS*nnPkg::ACT_W-1:0]      result,
	output logic                                     busy
);

	if (NUM_INPUTS > nnPkg::MAX_INPUTS || NUM_NEURONS > nnPkg::MAX_NEURONS)
	begin : gSizeCheck
		$error("denseLayer size is beyond the weight table");
	end

	logic [NUM_NEURONS-1:0] readReq;
	logic [NUM_NEURONS*5-1:0] reqAddr;
	logic [NUM_NEURONS-1:0] grant;
	logic [4:0] readAddr;
	logic signed [nnPkg::ACT_W-1:0] readData;
	logic [NUM_NEURONS-1:0] seen;   // engines that have finished since start
	logic lastDone;

	actBuffer #(.NUM_INPUTS(NUM_INPUTS)) actBuffer_i (
		.clk      (clk),
		.reset    (reset),
		.actWrite (actWrite),
		.actAddr  (actAddr),
		.actData  (actData),
		.readAddr (readAddr),
		.readData (readData)
	);

	actArbiter #(.NUM_NEURONS(NUM_NEURONS)) actArbiter_i (
		.clk      (clk),
		.reset    (reset),
		.readReq  (readReq),
		.reqAddr  (reqAddr),
		.grant    (grant),
		.readAddr (readAddr)
	);

	for (genvar n = 0; n < NUM_NEURONS; n++)
	begin : gEngine
		neuronEngine #(.NUM_INPUTS(NUM_INPUTS), .NEURON_ID(n)) neuronEngine_i (
			.clk      (clk),
			.reset    (reset),
			.start    (start),
			.grant    (grant[n]),
			.readData (readData),
			.readReq  (readReq[n]),
			.reqAddr  (reqAddr[n*5 +: 5]),
			.done     (done[n]),
			.result   (result[n*nnPkg::ACT_W +: nnPkg::ACT_W])
		);
	end

	assign lastDone = busy && (&(seen | done));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			seen <= '0;
		end
		else if (start && (!busy || lastDone))
		begin
			busy <= 1'b1;   // every engine is idle here, so all of them restart
			seen <= '0;
		end
		else if (lastDone)
		begin
			busy <= 1'b0;
			seen <= '0;
		end
		else if (busy)
		begin
			seen <= seen | done;
		end
	end

endmodule

// File: design/neuronEngine.sv
`timescale 1ns/1ps

module neuronEngine #(
	parameter int NUM_INPUTS = 30,
	parameter int NEURON_ID = 0
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            start,
	input  logic                            grant,
	input  logic signed [nnPkg::ACT_W-1:0]  readData,
	output logic                            readReq,
	output logic [4:0]                      reqAddr,
	output logic                            done,
	output logic [nnPkg::ACT_W-1:0]         result
);

	nnPkg::engineState state;
	logic [4:0] idx;
	logic pending;   // granted last cycle, so readData is ours now
	logic signed [nnPkg::ACT_W-1:0] actReg;
	logic [nnPkg::ACT_W-1:0] acc;
	logic signed [2*nnPkg::ACT_W-1:0] product;

	assign product = actReg * nnPkg::weightTable[NEURON_ID][idx];

	// the request drops as soon as it is granted
	assign readReq = (state == nnPkg::engFetch) && !pending;
	assign reqAddr = idx;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nnPkg::engIdle;
			idx <= '0;
			pending <= 1'b0;
			done <= 1'b0;
			result <= '0;
		end
		else
		begin
			done <= (state == nnPkg::engFinish);
			case (state)
				nnPkg::engIdle:
				begin
					if (start)
					begin
						idx <= '0;
						state <= nnPkg::engFetch;
					end
				end
				nnPkg::engFetch:
				begin
					if (pending)
					begin
						pending <= 1'b0;
						state <= nnPkg::engAccum;
					end
					else if (grant)
					begin
						pending <= 1'b1;
					end
				end
				nnPkg::engAccum:
				begin
					if (idx == 5'(NUM_INPUTS - 1))
					begin
						state <= nnPkg::engFinish;
					end
					else
					begin
						idx <= idx + 5'd1;
						state <= nnPkg::engFetch;
					end
				end
				nnPkg::engFinish:
				begin
					result <= acc[nnPkg::ACT_W-1] ? '0 : acc;   // ReLU on the sign bit
					state <= nnPkg::engIdle;
				end
				default:
				begin
					state <= nnPkg::engIdle;
				end
			endcase
		end
	end

	// datapath registers, loaded only when the FSM says so
	always_ff @(posedge clk)
	begin
		if (state == nnPkg::engIdle && start)
			acc <= nnPkg::biasTable[NEURON_ID];
		else if (state == nnPkg::engAccum)
			acc <= acc + product[nnPkg::ACT_W-1:0];   // wraps modulo 256
		if (state == nnPkg::engFetch && pending)
			actReg <= readData;
	end

	donePulse: assert property (@(posedge clk) disable iff (reset) done |=> !done);

	noReqWhenIdle: assert property (@(posedge clk) disable iff (reset)
		(state == nnPkg::engIdle) |-> !readReq);

endmodule

// File: design/nnPkg.sv
package nnPkg;

	localparam int MAX_INPUTS = 30;
	localparam int MAX_NEURONS = 4;
	localparam int ACT_W = 8;

	// one row per neuron, one column per input activation
	// row 0 is the original thirty-input neuron
	localparam logic signed [ACT_W-1:0] weightTable [MAX_NEURONS][MAX_INPUTS] = '{
		'{
			8'h27, 8'h4C, 8'h05, 8'h24, 8'hFB, 8'hE7, 8'hE5, 8'h31, 8'h39, 8'h31,
			8'h1E, 8'h5A, 8'hF3, 8'h41, 8'hA9, 8'h13, 8'h1D, 8'hB9, 8'hDF, 8'hC0,
			8'hF3, 8'h03, 8'h2C, 8'h2D, 8'h1D, 8'h2B, 8'hEC, 8'h17, 8'h06, 8'h04
		},
		'{
			8'h12, 8'hE0, 8'h33, 8'h07, 8'hF9, 8'h4A, 8'h1C, 8'hD5, 8'h08, 8'h61,
			8'hEE, 8'h25, 8'h03, 8'hC7, 8'h5E, 8'h10, 8'hF2, 8'h2A, 8'h39, 8'h9B,
			8'h06, 8'h44, 8'hFD, 8'h1B, 8'h70, 8'hC2, 8'h0D, 8'h29, 8'hE8, 8'h15
		},
		'{
			8'hF5, 8'h1A, 8'h6C, 8'h2E, 8'hB3, 8'h09, 8'h48, 8'hEA, 8'h3F, 8'h11,
			8'hD0, 8'h27, 8'h5B, 8'h04, 8'hCE, 8'h36, 8'h7A, 8'h13, 8'hE1, 8'h22,
			8'h0B, 8'h95, 8'h58, 8'h31, 8'hF7, 8'h1E, 8'h40, 8'hAC, 8'h0E, 8'h2B
		},
		'{
			8'h03, 8'hF1, 8'h27, 8'h60, 8'h1F, 8'hD9, 8'h0C, 8'h4E, 8'hB6, 8'h35,
			8'h18, 8'hE4, 8'h72, 8'h0A, 8'hC9, 8'h2D, 8'h14, 8'hA3, 8'h3B, 8'h05,
			8'hE6, 8'h51, 8'h20, 8'hFB, 8'h6A, 8'h17, 8'hDA, 8'h38, 8'h0F, 8'h8C
		}
	};

	// added once at the start of each sum
	localparam logic signed [ACT_W-1:0] biasTable [MAX_NEURONS] = '{
		8'sd11,
		-8'sd7,
		8'sd25,
		8'sd3
	};

	typedef enum logic [1:0]
	{
		engIdle,
		engFetch,   // waiting for the grant, then for the read data
		engAccum,
		engFinish
	} engineState;

endpackage

// File: dv/denseLayerTb.sv
`timescale 1ns/1ps

module denseLayerTb;

	localparam int NUM_INPUTS = 30;
	localparam int NUM_NEURONS = 2;
	localparam int CLK_PERIOD = 4;
	localparam int LATENCY_BOUND = NUM_INPUTS * (NUM_NEURONS + 1) + 4;
	localparam int SETTLE_CYCLES = 3;   // extra samples after the last done, to catch a repeat
	localparam int NUM_TESTS = 7;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * (NUM_INPUTS * (NUM_NEURONS + 1) + 40);

	localparam int KIND_ZERO = 0;
	localparam int KIND_MAX = 1;
	localparam int KIND_MIN = 2;
	localparam int KIND_RANDOM = 3;
	localparam int KIND_FIXED = 4;

	logic clk;
	logic reset;
	logic actWrite;
	logic [4:0] actAddr;
	logic signed [7:0] actData;
	logic start;
	logic [NUM_NEURONS-1:0] done;
	logic [NUM_NEURONS*8-1:0] result;
	logic busy;

	logic signed [7:0] actVec [NUM_INPUTS];   // vector currently held in the buffer
	int errorCount = 0;
	int failedTests = 0;

	// one row per test: activation pattern, second start while busy, name
	int patKind [NUM_TESTS] = '{KIND_ZERO, KIND_MAX, KIND_MIN, KIND_RANDOM, KIND_FIXED,
		KIND_RANDOM, KIND_FIXED};
	bit secondStart [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
	string testName [NUM_TESTS] = '{"zero vector", "all max", "all min", "random vector",
		"fixed ramp", "random with restart", "ramp with restart"};

	denseLayer denseLayer_i (
		.clk      (clk),
		.reset    (reset),
		.actWrite (actWrite),
		.actAddr  (actAddr),
		.actData  (actData),
		.start    (start),
		.done     (done),
		.result   (result),
		.busy     (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	task automatic checkValue(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (expected !== actual)
		begin
			errorCount++;
			$display("** Error at %0t: %s expected %0d, got %0d", $time, name,
				expected, actual);
		end
	endtask

	// wrapped 8-bit sum of low product bytes plus bias, then ReLU on bit 7
	function automatic logic [7:0] modelNeuron(input int n);
		logic [7:0] acc;
		logic signed [15:0] prod;
		acc = nnPkg::biasTable[n];
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			prod = actVec[i] * nnPkg::weightTable[n][i];
			acc = acc + prod[7:0];
		end
		return acc[7] ? 8'd0 : acc;
	endfunction

	task automatic fillVector(input int kind);
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			case (kind)
				KIND_ZERO: actVec[i] = 8'h00;
				KIND_MAX: actVec[i] = 8'h7F;
				KIND_MIN: actVec[i] = 8'h80;
				KIND_RANDOM: actVec[i] = 8'($urandom);
				default: actVec[i] = 8'(i * 37 - 60);
			endcase
		end
	endtask

	task automatic runTest(input int t);
		int doneCount [NUM_NEURONS];
		int errorsBefore;
		int cycle;
		int settle;
		bit allDone;
		errorsBefore = errorCount;
		fillVector(patKind[t]);
		for (int i = 0; i < NUM_INPUTS; i++)
		begin
			checkValue("busy", 8'h00, 8'(busy));   // the layer is idle while loading
			checkValue("done", 8'h00, 8'(done));
			actWrite = 1'b1;
			actAddr = 5'(i);
			actData = actVec[i];
			@(negedge clk);
		end
		actWrite = 1'b0;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		foreach (doneCount[n])
			doneCount[n] = 0;
		allDone = 1'b0;
		cycle = 1;
		settle = 0;
		while (settle < SETTLE_CYCLES && cycle <= LATENCY_BOUND + SETTLE_CYCLES)
		begin
			checkValue("busy", 8'(!allDone), 8'(busy));   // still high on the last done
			for (int n = 0; n < NUM_NEURONS; n++)
			begin
				if (done[n])
				begin
					doneCount[n]++;
					if (cycle > LATENCY_BOUND)
					begin
						errorCount++;
						$display("Error: neuron %0d finished late, %0d cycles after start",
							n, cycle);
					end
				end
			end
			allDone = 1'b1;
			foreach (doneCount[n])
				if (doneCount[n] == 0)
					allDone = 1'b0;
			if (allDone)
				settle++;
			start = secondStart[t] && (cycle == 3);   // engines are mid-fetch by now
			@(negedge clk);
			cycle++;
		end
		start = 1'b0;
		for (int n = 0; n < NUM_NEURONS; n++)
		begin
			if (doneCount[n] == 0)
			begin
				errorCount++;
				$display("Error: neuron %0d gave no done within %0d cycles of start", n,
					LATENCY_BOUND);
			end
			else if (doneCount[n] > 1)
			begin
				errorCount++;
				$display("Error: neuron %0d pulsed done %0d times for one start", n,
					doneCount[n]);
			end
			checkValue($sformatf("result[%0d]", n), modelNeuron(n), result[n*8 +: 8]);
		end
		if (errorCount != errorsBefore)
			failedTests++;
		$display("test %0d %s: %s", t, testName[t],
			(errorCount == errorsBefore) ? "ok" : "FAILED");
	endtask

	initial
	begin
		void'($urandom(32'h4af2629c));
		reset = 1'b1;
		actWrite = 1'b0;
		actAddr = '0;
		actData = '0;
		start = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		checkValue("busy", 8'h00, 8'(busy));
		for (int n = 0; n < NUM_NEURONS; n++)
		begin
			checkValue($sformatf("done[%0d]", n), 8'h00, 8'(done[n]));
			checkValue($sformatf("result[%0d]", n), 8'h00, result[n*8 +: 8]);
		end
		$display("reset state: %s", (errorCount == 0) ? "ok" : "FAILED");
		for (int t = 0; t < NUM_TESTS; t++)
			runTest(t);
		$display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failedTests, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: vlog.f
design/nnPkg.sv
design/actBuffer.sv
design/actArbiter.sv
design/neuronEngine.sv
design/denseLayer.sv
dv/denseLayerTb.sv
